/* source/eth_tx_defs.svh */
/*
  ethernet transmit constants
  preamble, start delimiter, inter-frame gap and minimum frame length
  shared by the transmit stages and the frame model
*/

`ifndef ETH_TX_DEFS_SVH
`define ETH_TX_DEFS_SVH

// ----------------------------------------------------------
// line framing
// ----------------------------------------------------------

// seven preamble bytes plus the start delimiter
`define ETH_PREAMBLE_LEN 8

// preamble bytes 55 followed by delimiter d5, first byte in the top octet
`define ETH_PREAMBLE_WORD 64'h55555555555555D5

// idle byte times between frames
`define ETH_IFG_LEN 12

// shortest frame before the fcs is added
`define ETH_MIN_PAYLOAD 60

`endif

/* source/eth_tx_pkg.sv */
/*
  ethernet transmit types
  octet and rgmii nibble words, plus the state encodings
  of the padding stage and the line output stage
*/

`default_nettype none

package eth_tx_pkg;

  // one octet on the byte stream
  typedef logic [7:0] byte_t;

  // half an octet on the rgmii data pins
  typedef logic [3:0] nibble_t;

  // padding stage
  typedef enum logic [1:0] {
    PAD_IDLE = 2'd0,
    PAD_PASS = 2'd1,
    PAD_FILL = 2'd2
  } pad_state_t;

  // line output stage
  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    TX_SEND = 2'd1,
    TX_GAP  = 2'd2
  } send_state_t;

endpackage

`default_nettype wire

/* source/frame_pad.sv */
/*
  frame padding stage
  forwards each frame byte one cycle later and, for frames shorter
  than the ethernet minimum, appends zero bytes up to that length
*/

`timescale 1ns/1ns
`include "eth_tx_defs.svh"
`default_nettype none

module frame_pad (
  input  wire logic             clock,
  input  wire logic             rst_n,
  input  wire logic             in_valid,
  input  wire eth_tx_pkg::byte_t in_data,
  input  wire logic             in_last,
  output logic                  pad_valid,
  output eth_tx_pkg::byte_t     pad_data,
  output logic                  pad_last,
  output logic                  in_frame
);

  import eth_tx_pkg::*;

  localparam logic [6:0] MIN_LEN = 7'(`ETH_MIN_PAYLOAD);

  pad_state_t state;
  // bytes emitted so far, held at MIN_LEN once reached
  logic [6:0] count;
  logic [6:0] count_inc;
  // frame would still be short after the current byte
  logic       short_frame;

  assign count_inc   = count + 7'd1;
  assign short_frame = (count_inc < MIN_LEN);

  // high from the first emitted byte through the last one
  assign in_frame = pad_valid | (state != PAD_IDLE);

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state     <= PAD_IDLE;
      count     <= '0;
      pad_valid <= 1'b0;
      pad_last  <= 1'b0;
    end else begin
      case (state)
        PAD_IDLE, PAD_PASS: begin
          pad_valid <= in_valid;
          // a real last byte only ends the frame once it is long enough
          pad_last  <= in_valid & in_last & ~short_frame;
          if (in_valid) begin
            count <= short_frame ? count_inc : MIN_LEN;
            if (!in_last) begin
              state <= PAD_PASS;
            end else if (short_frame) begin
              // source is done early, continue with zero bytes
              state <= PAD_FILL;
            end else begin
              state <= PAD_IDLE;
              count <= '0;
            end
          end
        end
        PAD_FILL: begin
          pad_valid <= 1'b1;
          pad_last  <= ~short_frame;
          if (short_frame) begin
            count <= count_inc;
          end else begin
            // this zero byte brings the frame to minimum size
            state <= PAD_IDLE;
            count <= '0;
          end
        end
        default: begin
          state     <= PAD_IDLE;
          count     <= '0;
          pad_valid <= 1'b0;
          pad_last  <= 1'b0;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // data
  // ----------------------------------------------------------

  // fill bytes are zero, otherwise the source byte
  always_ff @(posedge clock) begin
    pad_data <= (state == PAD_FILL) ? byte_t'(0) : in_data;
  end

endmodule

`default_nettype wire

/* source/fcs_append.sv */
/*
  fcs stage
  forwards the padded frame with one cycle latency, runs the
  ethernet crc-32 over it and appends the four fcs bytes
*/

`timescale 1ns/1ns
`default_nettype none

module fcs_append (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              pad_valid,
  input  wire eth_tx_pkg::byte_t pad_data,
  input  wire logic              pad_last,
  output logic                   fcs_valid,
  output eth_tx_pkg::byte_t      fcs_data,
  output logic                   in_frame
);

  import eth_tx_pkg::*;

  // polynomial 04c11db7 in bit-reversed form, lsb first
  localparam logic [31:0] CRC_POLY = 32'hEDB88320;
  localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

  logic [31:0] crc;
  // fcs bytes are being emitted
  logic        fcs_active;
  // which fcs byte goes out next, 0 is the least significant
  logic [1:0]  fcs_idx;
  byte_t       fcs_byte;

  // ----------------------------------------------------------
  // crc
  // ----------------------------------------------------------

  // one byte of the reflected crc, bit 0 of the byte first
  function automatic logic [31:0] crc_update(input logic [31:0] crc_in, input byte_t data);
    logic [31:0] c;
    c = crc_in ^ {24'd0, data};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  // fcs is the complemented remainder
  assign fcs_byte = ~crc[{fcs_idx, 3'b000} +: 8];

  // stays high while data or fcs bytes are still leaving
  assign in_frame = fcs_valid | fcs_active;

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      crc        <= CRC_INIT;
      fcs_valid  <= 1'b0;
      fcs_active <= 1'b0;
      fcs_idx    <= '0;
    end else begin
      // payload and fcs bytes form one unbroken run
      fcs_valid <= pad_valid | fcs_active;
      if (fcs_active) begin
        fcs_idx <= fcs_idx + 2'd1;
        if (fcs_idx == 2'd3) begin
          // last fcs byte, ready for the next frame
          fcs_active <= 1'b0;
          crc        <= CRC_INIT;
        end
      end else if (pad_valid) begin
        crc <= crc_update(crc, pad_data);
        if (pad_last) begin
          fcs_active <= 1'b1;
          fcs_idx    <= '0;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // data
  // ----------------------------------------------------------

  // fcs bytes follow the last payload byte directly
  always_ff @(posedge clock) begin
    if (fcs_active) begin
      fcs_data <= fcs_byte;
    end else begin
      fcs_data <= pad_data;
    end
  end

endmodule

`default_nettype wire

/* source/rgmii_send.sv */
/*
  rgmii line output
  prefixes preamble and start delimiter through a byte shift register,
  keeps the inter-frame gap and drives nibbles on both clock edges
*/

`timescale 1ns/1ns
`include "eth_tx_defs.svh"
`default_nettype none

module rgmii_send (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              fcs_valid,
  input  wire eth_tx_pkg::byte_t fcs_data,
  output logic                   active,
  output eth_tx_pkg::nibble_t    phy_tx,
  output logic                   phy_tx_en
);

  import eth_tx_pkg::*;

  localparam int SHIFT_W = 8 * `ETH_PREAMBLE_LEN;
  localparam int HI_BIT  = SHIFT_W - 1;

  localparam logic [HI_BIT:0] PREAMBLE  = SHIFT_W'(`ETH_PREAMBLE_WORD);
  // bytes still inside the shift register once the input stops
  localparam logic [3:0]      PURGE_LEN = 4'(`ETH_PREAMBLE_LEN - 1);
  localparam logic [3:0]      GAP_LEN   = 4'(`ETH_IFG_LEN);

  send_state_t     state;
  logic [HI_BIT:0] shift_reg;
  logic [3:0]      bytes_left;
  // a byte leaves the shift register this cycle
  logic            sending;
  byte_t           head_byte;

  // ddr output registers
  nibble_t         nib_lo;
  nibble_t         nib_hi;
  logic            tx_en_q;

  assign sending   = fcs_valid | (state == TX_SEND);
  assign active    = sending | (state == TX_GAP);
  // oldest byte, next to go on the line
  assign head_byte = shift_reg[HI_BIT -: 8];

  // ----------------------------------------------------------
  // shift register
  // ----------------------------------------------------------

  // preamble leads, each frame byte comes out 8 byte times later
  always_ff @(posedge clock) begin
    if (sending) begin
      shift_reg <= {shift_reg[HI_BIT-8:0], fcs_data};
    end else begin
      shift_reg <= PREAMBLE;
    end
  end

  // ----------------------------------------------------------
  // send and gap fsm
  // ----------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state      <= TX_IDLE;
      bytes_left <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          // first byte of a frame
          if (fcs_valid) begin
            state      <= TX_SEND;
            bytes_left <= PURGE_LEN;
          end
        end
        TX_SEND: begin
          if (fcs_valid) begin
            bytes_left <= PURGE_LEN;
          end else if (bytes_left != 4'd0) begin
            // input over, flush the tail of the shift register
            bytes_left <= bytes_left - 4'd1;
          end else begin
            state      <= TX_GAP;
            bytes_left <= GAP_LEN;
          end
        end
        TX_GAP: begin
          // line stays quiet, active still high
          if (bytes_left != 4'd0) begin
            bytes_left <= bytes_left - 4'd1;
          end else begin
            state <= TX_IDLE;
          end
        end
        default: begin
          state      <= TX_IDLE;
          bytes_left <= '0;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // ddr output
  // ----------------------------------------------------------

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      tx_en_q <= 1'b0;
    end else begin
      tx_en_q <= sending;
    end
  end

  always_ff @(posedge clock) begin
    nib_lo <= head_byte[3:0];
    nib_hi <= head_byte[7:4];
  end

  // low nibble while clock is high, high nibble while clock is low
  assign phy_tx    = clock ? nib_lo : nib_hi;
  // same level on both edges
  assign phy_tx_en = tx_en_q;

endmodule

`default_nettype wire

/* source/eth_tx_top.sv */
/*
  ethernet transmit path to an rgmii phy
  padding, fcs and line output in a chain, plus the busy level
  that tells the byte source when a new frame may start
*/

`timescale 1ns/1ns
`default_nettype none

module eth_tx_top (
  input  wire logic              clock,
  input  wire logic              rst_n,
  input  wire logic              in_valid,
  input  wire eth_tx_pkg::byte_t in_data,
  input  wire logic              in_last,
  output logic                   busy,
  output eth_tx_pkg::nibble_t    phy_tx,
  output logic                   phy_tx_en
);

  import eth_tx_pkg::*;

  // ----------------------------------------------------------
  // stage links
  // ----------------------------------------------------------

  // padded frame
  logic  pad_valid;
  byte_t pad_data;
  logic  pad_last;
  logic  pad_in_frame;

  // frame with fcs
  logic  fcs_valid;
  byte_t fcs_data;
  logic  fcs_in_frame;

  // line output incl. gap
  logic  line_active;

  // ----------------------------------------------------------
  // stages
  // ----------------------------------------------------------

  frame_pad frame_pad_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (in_last),
    .pad_valid (pad_valid),
    .pad_data  (pad_data),
    .pad_last  (pad_last),
    .in_frame  (pad_in_frame)
  );

  fcs_append fcs_append_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .pad_valid (pad_valid),
    .pad_data  (pad_data),
    .pad_last  (pad_last),
    .fcs_valid (fcs_valid),
    .fcs_data  (fcs_data),
    .in_frame  (fcs_in_frame)
  );

  rgmii_send rgmii_send_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .fcs_valid (fcs_valid),
    .fcs_data  (fcs_data),
    .active    (line_active),
    .phy_tx    (phy_tx),
    .phy_tx_en (phy_tx_en)
  );

  // any stage still holding part of a frame, or the gap running
  assign busy = pad_in_frame | fcs_in_frame | line_active;

endmodule

`default_nettype wire

/* tests/eth_tx_tb.sv */
/*
  ethernet transmit path testbench
  sends random frames, rebuilds the rgmii line bytes and compares
  them with a frame model of preamble, padding and crc-32
*/

`timescale 1ns/1ns
`include "eth_tx_defs.svh"
`default_nettype none

module eth_tx_tb;

  import eth_tx_pkg::*;

  typedef byte_t byte_q_t[$];

  localparam int NUM_FRAMES    = 24;
  // cycles from the first input byte to phy_tx_en
  localparam int LINE_DELAY    = 3;
  localparam int IDLE_TIMEOUT  = 200;
  localparam int FRAME_TIMEOUT = 400;

  logic    clock = 1'b0;
  logic    rst_n;
  logic    in_valid;
  byte_t   in_data;
  logic    in_last;
  logic    busy;
  nibble_t phy_tx;
  logic    phy_tx_en;

  logic [31:0] lfsr;
  int          cycle = 0;
  int          frames_checked = 0;

  // queues of expected and captured frames and bytes
  byte_q_t exp_bytes;
  int      exp_lens[$];
  int      start_cycles[$];
  byte_q_t got_bytes;
  int      got_lens[$];
  int      rise_cycles[$];

  eth_tx_top eth_tx_top_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_last   (in_last),
    .busy      (busy),
    .phy_tx    (phy_tx),
    .phy_tx_en (phy_tx_en)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one step per bit
  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // expected line bytes with preamble, padded payload and fcs lsb first
  function automatic byte_q_t line_frame(input byte_q_t payload);
    byte_q_t     frame;
    byte_q_t     line;
    logic [63:0] pre;
    logic [31:0] crc;
    logic        fb;
    pre   = `ETH_PREAMBLE_WORD;
    frame = payload;
    while (frame.size() < `ETH_MIN_PAYLOAD) begin
      frame.push_back(8'h00);
    end
    // reflected crc over one data bit at a time
    crc = 32'hFFFFFFFF;
    foreach (frame[i]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[0] ^ frame[i][b];
        crc = crc >> 1;
        if (fb) begin
          crc = crc ^ 32'hEDB88320;
        end
      end
    end
    crc = ~crc;
    for (int i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
      line.push_back(pre[63 - 8 * i -: 8]);
    end
    foreach (frame[i]) begin
      line.push_back(frame[i]);
    end
    for (int i = 0; i < 4; i++) begin
      line.push_back(crc[8 * i +: 8]);
    end
    return line;
  endfunction

  // inputs change 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #5;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      next_cycle();
      n++;
      if (n > IDLE_TIMEOUT) begin
        report_failure("busy did not fall after a frame");
      end
    end
  endtask

  task automatic send_frame(input byte_q_t payload);
    for (int i = 0; i < payload.size(); i++) begin
      if (i == 0) begin
        start_cycles.push_back(cycle);
      end
      in_valid = 1'b1;
      in_data  = payload[i];
      in_last  = (i == payload.size() - 1);
      next_cycle();
      check_value("busy", 32'(busy), 32'd1);
    end
    in_valid = 1'b0;
    // nonzero idle data so that fill bytes cannot come from the input
    in_data  = 8'hff;
    in_last  = 1'b0;
  endtask

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  initial begin : stimulus
    byte_q_t     payload;
    byte_q_t     line;
    logic [31:0] r;
    int          len;
    int          gap;
    int          n;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_data  = 8'h00;
    in_last  = 1'b0;
    lfsr     = 32'ha683;
    repeat (5) @(posedge clock);
    #5;
    rst_n = 1'b1;
    next_cycle();
    check_value("busy", 32'(busy), 32'd0);
    check_value("phy_tx_en", 32'(phy_tx_en), 32'd0);

    for (int f = 0; f < NUM_FRAMES; f++) begin
      // length 1 to 100
      take_bits(7, r);
      len = int'(r % 32'd100) + 1;
      payload.delete();
      for (int i = 0; i < len; i++) begin
        take_bits(8, r);
        payload.push_back(r[7:0]);
      end
      // values above 20 give a back-to-back frame
      take_bits(5, r);
      gap  = (r > 32'd20) ? 0 : int'(r);
      line = line_frame(payload);
      exp_lens.push_back(line.size());
      foreach (line[i]) begin
        exp_bytes.push_back(line[i]);
      end
      wait_idle();
      send_frame(payload);
      repeat (gap) next_cycle();
    end

    n = 0;
    while (frames_checked < NUM_FRAMES) begin
      next_cycle();
      n++;
      if (n > FRAME_TIMEOUT) begin
        report_failure("not all frames were seen on the line");
      end
    end
    $display("No errors");
    $finish;
  end

  // ----------------------------------------------------------
  // line capture
  // ----------------------------------------------------------

  // low nibble after the rising edge, high nibble after the falling edge
  initial begin : capture
    logic    en_lo;
    logic    en_hi;
    logic    busy_s;
    logic    was_en;
    logic    seen_frame;
    nibble_t lo;
    nibble_t hi;
    int      now;
    int      frame_len;
    int      fall_cycle;
    was_en     = 1'b0;
    seen_frame = 1'b0;
    frame_len  = 0;
    fall_cycle = 0;
    forever begin
      @(posedge clock);
      #10;
      en_lo  = phy_tx_en;
      lo     = phy_tx;
      busy_s = busy;
      now    = cycle;
      @(negedge clock);
      #10;
      en_hi = phy_tx_en;
      hi    = phy_tx;
      // enable holds its level on both edges
      check_value("phy_tx_en", 32'(en_hi), 32'(en_lo));
      if (en_lo === 1'b1) begin
        if (!was_en) begin
          if (seen_frame && (now - fall_cycle < `ETH_IFG_LEN)) begin
            report_failure("inter-frame gap on the line is shorter than 12 cycles");
          end
          rise_cycles.push_back(now);
          frame_len = 0;
        end
        got_bytes.push_back({hi, lo});
        frame_len++;
        check_value("busy", 32'(busy_s), 32'd1);
      end else begin
        if (was_en) begin
          got_lens.push_back(frame_len);
          fall_cycle = now;
          seen_frame = 1'b1;
        end
        // busy covers the whole gap
        if (seen_frame && (now - fall_cycle < `ETH_IFG_LEN)) begin
          check_value("busy", 32'(busy_s), 32'd1);
        end
      end
      was_en = (en_lo === 1'b1);
    end
  end

  // ----------------------------------------------------------
  // compare
  // ----------------------------------------------------------

  initial begin : compare
    int len;
    int exp_len;
    int n;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      n = 0;
      while (got_lens.size() == 0) begin
        @(posedge clock);
        n++;
        if (n > FRAME_TIMEOUT) begin
          report_failure("no frame appeared on phy_tx_en in time");
        end
      end
      if (exp_lens.size() == 0) begin
        report_failure("a frame appeared on the line that was never sent");
      end
      len     = got_lens.pop_front();
      exp_len = exp_lens.pop_front();
      check_value("phy_tx_en length", len, exp_len);
      check_value("phy_tx_en delay", rise_cycles.pop_front() - start_cycles.pop_front(),
                  LINE_DELAY);
      for (int i = 0; i < len; i++) begin
        check_value("phy_tx", 32'(got_bytes.pop_front()), 32'(exp_bytes.pop_front()));
      end
      frames_checked++;
    end
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/eth_tx_pkg.sv
source/frame_pad.sv
source/fcs_append.sv
source/rgmii_send.sv
source/eth_tx_top.sv
tests/eth_tx_tb.sv

/* Makefile */
# Verilator build and run for the ethernet transmit path
# override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= eth_tx_tb
DUT_TOP   ?= eth_tx_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail
run: build
	-$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended early, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
